//--- include/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// operand and result width.
`define EXU_XLEN 32

// tag width, 16 operations in flight.
`define EXU_TAG_W 4

// multiplier pipeline depth.
`define EXU_MUL_STAGES 3

`endif

//--- src/exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]  xlen_t;
    typedef logic [`EXU_TAG_W-1:0] tag_t;

    // target functional unit.
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_e;

    // raw code, meaning depends on the unit.
    typedef logic [3:0] op_e;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [3:0] {
        OP_MUL   = 4'd0,
        OP_MULH  = 4'd1,
        OP_MULHU = 4'd2
    } mul_op_e;

    typedef enum logic [3:0] {
        OP_DIV  = 4'd0,
        OP_DIVU = 4'd1,
        OP_REM  = 4'd2,
        OP_REMU = 4'd3
    } div_op_e;

    typedef struct packed {
        tag_t  tag;
        xlen_t result;
        logic  exception; // divide by zero.
    } wb_t;

endpackage

//--- src/exu_if.sv
`timescale 1ns/1ps

// shared issue bus, every unit filters on the unit field.
interface exu_issue_if;
    logic           valid;
    exu_pkg::unit_e unit;
    exu_pkg::op_e   op;
    exu_pkg::tag_t  tag;
    exu_pkg::xlen_t operand_a;
    exu_pkg::xlen_t operand_b;

    modport driver (output valid, unit, op, tag, operand_a, operand_b);
    modport receiver (input valid, unit, op, tag, operand_a, operand_b);
endinterface

// one per unit, unit to arbiter.
interface exu_wb_if;
    logic         valid;
    logic         ready;
    exu_pkg::wb_t payload;

    modport source (
        output valid,
        output payload,
        input  ready
    );
    modport sink (
        input  valid,
        input  payload,
        output ready
    );
endinterface

//--- src/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    input  logic          clk_i,
    input  logic          rst_n_i,
    exu_issue_if.receiver issue,
    output logic          ready_o,
    exu_wb_if.source      wb
);
    logic           accept;
    logic [4:0]     shamt;
    exu_pkg::xlen_t result;
    logic           out_valid_q;
    exu_pkg::wb_t   out_q;

    assign ready_o = !out_valid_q || wb.ready; // empty or draining.
    assign accept  = issue.valid && (issue.unit == exu_pkg::UNIT_ALU) && ready_o;
    assign shamt   = issue.operand_b[4:0];

    always_comb begin
        case (issue.op)
            exu_pkg::OP_ADD:  result = issue.operand_a + issue.operand_b;
            exu_pkg::OP_SUB:  result = issue.operand_a - issue.operand_b;
            exu_pkg::OP_AND:  result = issue.operand_a & issue.operand_b;
            exu_pkg::OP_OR:   result = issue.operand_a | issue.operand_b;
            exu_pkg::OP_XOR:  result = issue.operand_a ^ issue.operand_b;
            exu_pkg::OP_SLL:  result = issue.operand_a << shamt;
            exu_pkg::OP_SRL:  result = issue.operand_a >> shamt;
            exu_pkg::OP_SRA:  result = $signed(issue.operand_a) >>> shamt;
            exu_pkg::OP_SLT:  result = {31'b0, $signed(issue.operand_a) < $signed(issue.operand_b)};
            exu_pkg::OP_SLTU: result = {31'b0, issue.operand_a < issue.operand_b};
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (wb.ready) begin
            out_valid_q <= 1'b0; // granted.
        end
    end

    // held until the arbiter takes it.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_q <= '{tag: issue.tag, result: result, exception: 1'b0};
        end
    end

    assign wb.valid   = out_valid_q;
    assign wb.payload = out_q;

endmodule

//--- src/exu_multiplier.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_multiplier (
    input  logic          clk_i,
    input  logic          rst_n_i,
    exu_issue_if.receiver issue,
    output logic          ready_o,
    exu_wb_if.source      wb
);
    localparam int unsigned LAST = `EXU_MUL_STAGES - 1;

    logic [`EXU_MUL_STAGES-1:0] valid_q;
    exu_pkg::tag_t              tag_q  [`EXU_MUL_STAGES];
    exu_pkg::op_e               op_q   [`EXU_MUL_STAGES];
    logic [2*`EXU_XLEN-1:0]     prod_q [`EXU_MUL_STAGES];
    logic                       accept, advance, sign_ext;
    logic [2*`EXU_XLEN-1:0]     ext_a, ext_b, product;
    exu_pkg::xlen_t             result;

    // a stalled last stage freezes everything.
    assign advance = !valid_q[LAST] || wb.ready;
    assign ready_o = advance;
    assign accept  = issue.valid && (issue.unit == exu_pkg::UNIT_MUL) && advance;

    // mulhu is the only unsigned form, low word does not care.
    assign sign_ext = (issue.op != exu_pkg::OP_MULHU);
    assign ext_a    = {{`EXU_XLEN{sign_ext & issue.operand_a[`EXU_XLEN-1]}}, issue.operand_a};
    assign ext_b    = {{`EXU_XLEN{sign_ext & issue.operand_b[`EXU_XLEN-1]}}, issue.operand_b};
    assign product  = ext_a * ext_b; // modulo 2^64 is the signed product too.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[LAST-1:0], accept};
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            tag_q[0]  <= issue.tag;
            op_q[0]   <= issue.op;
            prod_q[0] <= product;
            for (int i = 1; i < `EXU_MUL_STAGES; i++) begin
                tag_q[i]  <= tag_q[i-1];
                op_q[i]   <= op_q[i-1];
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    assign result = (op_q[LAST] == exu_pkg::OP_MUL) ? prod_q[LAST][`EXU_XLEN-1:0]
                                                    : prod_q[LAST][2*`EXU_XLEN-1:`EXU_XLEN];

    assign wb.valid   = valid_q[LAST];
    assign wb.payload = '{tag: tag_q[LAST], result: result, exception: 1'b0};

endmodule

//--- src/exu_divider.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_divider (
    input  logic          clk_i,
    input  logic          rst_n_i,
    exu_issue_if.receiver issue,
    output logic          ready_o,
    exu_wb_if.source      wb
);
    localparam int unsigned CNT_W = $clog2(`EXU_XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EXU_XLEN - 1);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

    state_e             state_q;
    logic [CNT_W-1:0]   cnt_q;
    exu_pkg::tag_t      tag_q;
    exu_pkg::xlen_t     divisor_q, quo_q, rem_q, res_q;
    logic               is_rem_q, quo_neg_q, rem_neg_q, exc_q;
    logic               accept, div_zero, op_signed, op_rem, a_neg, b_neg;
    exu_pkg::xlen_t     a_mag, b_mag, step_quo, step_rem, fix_quo, fix_rem;
    logic [`EXU_XLEN:0] shifted, trial;

    assign ready_o   = (state_q == S_IDLE);
    assign accept    = issue.valid && (issue.unit == exu_pkg::UNIT_DIV) && ready_o;
    assign div_zero  = (issue.operand_b == '0);
    assign op_signed = (issue.op == exu_pkg::OP_DIV) || (issue.op == exu_pkg::OP_REM);
    assign op_rem    = (issue.op == exu_pkg::OP_REM) || (issue.op == exu_pkg::OP_REMU);
    assign a_neg     = op_signed && issue.operand_a[`EXU_XLEN-1];
    assign b_neg     = op_signed && issue.operand_b[`EXU_XLEN-1];
    assign a_mag     = a_neg ? -issue.operand_a : issue.operand_a;
    assign b_mag     = b_neg ? -issue.operand_b : issue.operand_b;

    // one restoring step, quotient bits shift in from the right.
    assign shifted  = {rem_q, quo_q[`EXU_XLEN-1]};
    assign trial    = shifted - {1'b0, divisor_q};
    assign step_quo = {quo_q[`EXU_XLEN-2:0], !trial[`EXU_XLEN]};
    assign step_rem = trial[`EXU_XLEN] ? shifted[`EXU_XLEN-1:0] : trial[`EXU_XLEN-1:0];

    // min / -1 lands on the dividend by itself, magnitude 2^31 with no negation.
    assign fix_quo = quo_neg_q ? -step_quo : step_quo;
    assign fix_rem = rem_neg_q ? -step_rem : step_rem;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (accept) begin
                    state_q <= div_zero ? S_DONE : S_RUN; // zero divisor skips the loop.
                    cnt_q   <= '0;
                end
                S_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LAST_STEP) state_q <= S_DONE;
                end
                S_DONE:  if (wb.ready) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tag_q     <= issue.tag;
            divisor_q <= b_mag;
            quo_q     <= a_mag;
            rem_q     <= '0;
            is_rem_q  <= op_rem;
            quo_neg_q <= a_neg ^ b_neg;
            rem_neg_q <= a_neg; // remainder follows the dividend.
            exc_q     <= div_zero;
            res_q     <= op_rem ? issue.operand_a : '1; // divide by zero result.
        end else if (state_q == S_RUN) begin
            quo_q <= step_quo;
            rem_q <= step_rem;
            if (cnt_q == LAST_STEP) res_q <= is_rem_q ? fix_rem : fix_quo;
        end
    end

    assign wb.valid   = (state_q == S_DONE);
    assign wb.payload = '{tag: tag_q, result: res_q, exception: exc_q};

endmodule

//--- src/exu_wb_arbiter.sv
`timescale 1ns/1ps

module exu_wb_arbiter (
    exu_wb_if.sink       div_wb,
    exu_wb_if.sink       mul_wb,
    exu_wb_if.sink       alu_wb,
    output logic         wb_valid_o,
    input  logic         wb_ready_i,
    output exu_pkg::wb_t wb_o
);

    assign wb_valid_o = div_wb.valid || mul_wb.valid || alu_wb.valid;

    // divider first, it blocks new divides while waiting.
    always_comb begin
        div_wb.ready = 1'b0;
        mul_wb.ready = 1'b0;
        alu_wb.ready = 1'b0;
        wb_o         = alu_wb.payload;

        if (div_wb.valid) begin
            wb_o         = div_wb.payload;
            div_wb.ready = wb_ready_i;
        end else if (mul_wb.valid) begin
            wb_o         = mul_wb.payload;
            mul_wb.ready = wb_ready_i;
        end else if (alu_wb.valid) begin
            alu_wb.ready = wb_ready_i; // payload already defaulted.
        end
    end

endmodule

//--- src/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           issue_valid_i,
    input  exu_pkg::unit_e issue_unit_i,
    input  exu_pkg::op_e   issue_op_i,
    input  exu_pkg::tag_t  issue_tag_i,
    input  exu_pkg::xlen_t issue_a_i,
    input  exu_pkg::xlen_t issue_b_i,
    output logic           issue_ready_o,
    output logic           wb_valid_o,
    input  logic           wb_ready_i,
    output exu_pkg::tag_t  wb_tag_o,
    output exu_pkg::xlen_t wb_result_o,
    output logic           wb_exception_o
);
    logic         alu_ready, mul_ready, div_ready;
    exu_pkg::wb_t wb;

    exu_issue_if issue ();
    exu_wb_if    alu_wb ();
    exu_wb_if    mul_wb ();
    exu_wb_if    div_wb ();

    assign issue.valid     = issue_valid_i;
    assign issue.unit      = issue_unit_i;
    assign issue.op        = issue_op_i;
    assign issue.tag       = issue_tag_i;
    assign issue.operand_a = issue_a_i;
    assign issue.operand_b = issue_b_i;

    // ready of the addressed unit only.
    always_comb begin
        case (issue_unit_i)
            exu_pkg::UNIT_MUL: issue_ready_o = mul_ready;
            exu_pkg::UNIT_DIV: issue_ready_o = div_ready;
            default:           issue_ready_o = alu_ready;
        endcase
    end

    exu_alu i_alu (.clk_i, .rst_n_i, .issue(issue), .ready_o(alu_ready), .wb(alu_wb));

    exu_multiplier i_mul (.clk_i, .rst_n_i, .issue(issue), .ready_o(mul_ready), .wb(mul_wb));

    exu_divider i_div (.clk_i, .rst_n_i, .issue(issue), .ready_o(div_ready), .wb(div_wb));

    exu_wb_arbiter i_arb (
        .div_wb     (div_wb),
        .mul_wb     (mul_wb),
        .alu_wb     (alu_wb),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_o       (wb)
    );

    assign wb_tag_o       = wb.tag;
    assign wb_result_o    = wb.result;
    assign wb_exception_o = wb.exception;

endmodule

//--- dv/tb_exu_top.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module tb_exu_top;
    localparam int RESET_CYCLES = 8;
    localparam int PASSES       = 2; // second pass runs with random back-pressure.
    localparam int MAX_ENTRIES  = 48;
    localparam int N_TAGS       = 1 << `EXU_TAG_W;

    logic           clk_i = 1'b0;
    logic           rst_n_i, issue_valid_i, wb_ready_i;
    exu_pkg::unit_e issue_unit_i;
    exu_pkg::op_e   issue_op_i;
    exu_pkg::tag_t  issue_tag_i, wb_tag_o;
    exu_pkg::xlen_t issue_a_i, issue_b_i, wb_result_o;
    logic           issue_ready_o, wb_valid_o, wb_exception_o;

    // stimulus table.
    string          tbl_name  [MAX_ENTRIES];
    exu_pkg::unit_e tbl_unit  [MAX_ENTRIES];
    exu_pkg::op_e   tbl_op    [MAX_ENTRIES];
    exu_pkg::xlen_t tbl_a     [MAX_ENTRIES];
    exu_pkg::xlen_t tbl_b     [MAX_ENTRIES];
    exu_pkg::xlen_t tbl_res   [MAX_ENTRIES];
    logic           tbl_exc   [MAX_ENTRIES];
    bit             tbl_burst [MAX_ENTRIES]; // must issue without a stall.
    int             n_entries = 0;

    bit             sb_busy [N_TAGS]; // scoreboard by tag.
    int             sb_idx  [N_TAGS];
    int             n_issued = 0;
    int             n_returned = 0;
    int             pass = 0;
    bit             held = 1'b0;
    exu_pkg::wb_t   held_wb;

    exu_top i_exu_top (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        #1;
        wb_ready_i = (pass == 1) ? 1'($urandom % 2) : 1'b1;
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input exu_pkg::xlen_t exp,
                                input exu_pkg::xlen_t act);
        if (act !== exp) begin
            $display("error %s: result expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_exception(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: exception expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input exu_pkg::tag_t tag);
        if (!sb_busy[tag]) begin
            $display("error %s: tag %0d came back but was not outstanding", name, tag);
            abort_run();
        end
    endtask

    function automatic int unit_rank(input exu_pkg::unit_e unit);
        return (unit == exu_pkg::UNIT_DIV) ? 2 : (unit == exu_pkg::UNIT_MUL) ? 1 : 0;
    endfunction

    // reference model from the ISA rules.
    function automatic exu_pkg::xlen_t ref_result(input exu_pkg::unit_e unit,
            input exu_pkg::op_e op, input exu_pkg::xlen_t a, input exu_pkg::xlen_t b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        int                 sa, sb;
        bit                 ovf;
        sp  = $signed(a) * $signed(b);
        up  = {32'b0, a} * {32'b0, b};
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (sb == -1);
        if (unit == exu_pkg::UNIT_ALU) begin
            case (op)
                exu_pkg::OP_ADD:  return a + b;
                exu_pkg::OP_SUB:  return a - b;
                exu_pkg::OP_AND:  return a & b;
                exu_pkg::OP_OR:   return a | b;
                exu_pkg::OP_XOR:  return a ^ b;
                exu_pkg::OP_SLL:  return a << b[4:0];
                exu_pkg::OP_SRL:  return a >> b[4:0];
                exu_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
                exu_pkg::OP_SLT:  return (sa < sb) ? 1 : 0;
                default:          return (a < b) ? 1 : 0;
            endcase
        end
        if (unit == exu_pkg::UNIT_MUL) begin
            if (op == exu_pkg::OP_MUL) return sp[31:0];
            return (op == exu_pkg::OP_MULH) ? sp[63:32] : up[63:32];
        end
        if (b == 0) return (op == exu_pkg::OP_REM || op == exu_pkg::OP_REMU) ? a : '1;
        if (op == exu_pkg::OP_DIV) return ovf ? a : exu_pkg::xlen_t'(sa / sb);
        if (op == exu_pkg::OP_REM) return ovf ? '0 : exu_pkg::xlen_t'(sa % sb);
        return (op == exu_pkg::OP_DIVU) ? a / b : a % b;
    endfunction

    task automatic add_entry(input string name, input exu_pkg::unit_e unit,
            input exu_pkg::op_e op, input exu_pkg::xlen_t a, input exu_pkg::xlen_t b,
            input exu_pkg::xlen_t res, input logic exc, input bit burst = 1'b0);
        tbl_name[n_entries]  = name;
        tbl_unit[n_entries]  = unit;
        tbl_op[n_entries]    = op;
        tbl_a[n_entries]     = a;
        tbl_b[n_entries]     = b;
        tbl_res[n_entries]   = res;
        tbl_exc[n_entries]   = exc;
        tbl_burst[n_entries] = burst;
        n_entries++;
    endtask

    task automatic add_random(input string name, input exu_pkg::unit_e unit,
                              input exu_pkg::op_e op, input bit burst);
        exu_pkg::xlen_t a, b;
        a = $urandom;
        b = ($urandom % 8 == 0) ? exu_pkg::xlen_t'($urandom % 4) : exu_pkg::xlen_t'($urandom);
        add_entry(name, unit, op, a, b, ref_result(unit, op, a, b),
                  (unit == exu_pkg::UNIT_DIV) && (b == 0), burst);
    endtask

    task automatic build_table();
        add_entry("add_wrap", exu_pkg::UNIT_ALU, exu_pkg::OP_ADD, 32'h7fffffff, 1, 32'h80000000, 0);
        add_entry("sub_neg", exu_pkg::UNIT_ALU, exu_pkg::OP_SUB, 0, 1, 32'hffffffff, 0);
        add_entry("sll_33", exu_pkg::UNIT_ALU, exu_pkg::OP_SLL, 1, 33, 2, 0);
        add_entry("srl_36", exu_pkg::UNIT_ALU, exu_pkg::OP_SRL, 32'h80000000, 36, 32'h08000000, 0);
        add_entry("sra_neg", exu_pkg::UNIT_ALU, exu_pkg::OP_SRA, 32'hfffffff0, 35, 32'hfffffffe, 0);
        add_entry("slt_mix", exu_pkg::UNIT_ALU, exu_pkg::OP_SLT, 32'hffffffff, 1, 1, 0);
        add_entry("sltu_mix", exu_pkg::UNIT_ALU, exu_pkg::OP_SLTU, 32'hffffffff, 1, 0, 0);
        add_entry("mul_max", exu_pkg::UNIT_MUL, exu_pkg::OP_MUL, 32'h7fffffff, 32'h7fffffff, 1, 0);
        add_entry("mulh_min", exu_pkg::UNIT_MUL, exu_pkg::OP_MULH, 32'h80000000, 32'h80000000,
                  32'h40000000, 0);
        add_entry("mulh_min_m1", exu_pkg::UNIT_MUL, exu_pkg::OP_MULH, 32'h80000000, '1, 0, 0);
        add_entry("mulhu_max", exu_pkg::UNIT_MUL, exu_pkg::OP_MULHU, '1, '1, 32'hfffffffe, 0);
        add_entry("div_neg", exu_pkg::UNIT_DIV, exu_pkg::OP_DIV, 32'hfffffff9, 2, 32'hfffffffd, 0);
        add_entry("rem_neg", exu_pkg::UNIT_DIV, exu_pkg::OP_REM, 32'hfffffff9, 2, 32'hffffffff, 0);
        add_entry("div_ovf", exu_pkg::UNIT_DIV, exu_pkg::OP_DIV, 32'h80000000, '1, 32'h80000000, 0);
        add_entry("rem_ovf", exu_pkg::UNIT_DIV, exu_pkg::OP_REM, 32'h80000000, '1, 0, 0);
        add_entry("div_zero", exu_pkg::UNIT_DIV, exu_pkg::OP_DIV, 5, 0, 32'hffffffff, 1);
        add_entry("remu_zero", exu_pkg::UNIT_DIV, exu_pkg::OP_REMU, 32'h1234, 0, 32'h1234, 1);
        for (int i = 0; i < 5; i++) begin
            add_random($sformatf("rand_alu_%0d", i), exu_pkg::UNIT_ALU,
                       exu_pkg::op_e'($urandom_range(9, 0)), 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            add_random($sformatf("rand_mul_%0d", i), exu_pkg::UNIT_MUL,
                       exu_pkg::op_e'($urandom_range(2, 0)), 1'b1);
        end
        for (int i = 0; i < 5; i++) begin
            add_random($sformatf("rand_div_%0d", i), exu_pkg::UNIT_DIV,
                       exu_pkg::op_e'($urandom_range(3, 0)), 1'b0);
        end
    endtask

    task automatic wait_drained();
        issue_valid_i = 1'b0;
        while (n_returned != n_issued) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // entered and left 1 ns after a rising edge.
    task automatic issue_entry(input int idx, input bit must_be_fast);
        exu_pkg::tag_t tag;
        tag = exu_pkg::tag_t'(idx);
        while (sb_busy[tag]) begin
            issue_valid_i = 1'b0;
            @(posedge clk_i);
            #1;
        end
        issue_valid_i = 1'b1;
        issue_unit_i  = tbl_unit[idx];
        issue_op_i    = tbl_op[idx];
        issue_tag_i   = tag;
        issue_a_i     = tbl_a[idx];
        issue_b_i     = tbl_b[idx];
        @(negedge clk_i);
        while (!issue_ready_o) begin
            if (must_be_fast) begin
                $display("multiplier stalled on back-to-back issue of %s", tbl_name[idx]);
                abort_run();
            end
            @(negedge clk_i);
        end
        sb_busy[tag] = 1'b1; // transfers on the coming edge.
        sb_idx[tag]  = idx;
        n_issued++;
        @(posedge clk_i);
        #1;
    endtask

    always @(negedge clk_i) begin
        int idx;
        if (rst_n_i) begin
            if (held && !wb_valid_o) begin
                $display("wb_valid_o dropped while the writeback was stalled");
                abort_run();
            end else if (held && wb_tag_o == held_wb.tag) begin
                check_result("stall_hold", held_wb.result, wb_result_o);
                check_exception("stall_hold", held_wb.exception, wb_exception_o);
            end else if (held) begin
                // only a higher-priority unit may take over a stalled bus.
                check_tag("stall_takeover", wb_tag_o);
                if (unit_rank(tbl_unit[sb_idx[wb_tag_o]]) <=
                    unit_rank(tbl_unit[sb_idx[held_wb.tag]])) begin
                    $display("stalled writeback of tag %0d replaced by tag %0d of lower priority",
                             held_wb.tag, wb_tag_o);
                    abort_run();
                end
            end
            if (wb_valid_o && wb_ready_i) begin
                check_tag("writeback", wb_tag_o);
                idx = sb_idx[wb_tag_o];
                check_result(tbl_name[idx], tbl_res[idx], wb_result_o);
                check_exception(tbl_name[idx], tbl_exc[idx], wb_exception_o);
                sb_busy[wb_tag_o] = 1'b0;
                n_returned++;
            end
            held    = wb_valid_o && !wb_ready_i;
            held_wb = '{tag: wb_tag_o, result: wb_result_o, exception: wb_exception_o};
        end
    end

    initial begin
        #1;
        repeat (RESET_CYCLES + PASSES * n_entries * (`EXU_XLEN + 10)) @(posedge clk_i);
        $display("watchdog expired, the run hung with %0d results outstanding",
                 n_issued - n_returned);
        abort_run();
    end

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_unit_i  = exu_pkg::UNIT_ALU;
        issue_op_i    = '0;
        issue_tag_i   = '0;
        issue_a_i     = '0;
        issue_b_i     = '0;
        wb_ready_i    = 1'b1;
        void'($urandom(72));
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        // one cycle per unit, ready looked at mid-cycle.
        for (int u = 0; u < 3; u++) begin
            issue_unit_i = exu_pkg::unit_e'(u);
            @(negedge clk_i);
            if (wb_valid_o !== 1'b0) begin
                $display("wb_valid_o is high after reset");
                abort_run();
            end
            if (issue_ready_o !== 1'b1) begin
                $display("issue_ready_o is low after reset for unit %0d", u);
                abort_run();
            end
            @(posedge clk_i);
            #1;
        end
        for (int p = 0; p < PASSES; p++) begin
            pass = p;
            for (int i = 0; i < n_entries; i++) begin
                if (p == 0 && tbl_burst[i] && (i == 0 || !tbl_burst[i-1])) wait_drained();
                issue_entry(i, (p == 0) && tbl_burst[i]);
            end
            wait_drained();
        end
        pass = PASSES;
        if (wb_valid_o === 1'b0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("tag %0d showed up after every issued operation had returned", wb_tag_o);
            abort_run();
        end
    end

endmodule

//--- src.f
+incdir+include
src/exu_pkg.sv
src/exu_if.sv
src/exu_alu.sv
src/exu_multiplier.sv
src/exu_divider.sv
src/exu_wb_arbiter.sv
src/exu_top.sv
dv/tb_exu_top.sv

//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - include
    files:
      - src/exu_pkg.sv
      - src/exu_if.sv
      - src/exu_alu.sv
      - src/exu_multiplier.sv
      - src/exu_divider.sv
      - src/exu_wb_arbiter.sv
      - src/exu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_exu_top.sv
